// File: vec_mem_pkg.sv
/*
 * Memory side definitions
 * RAM geometry, download stream, file index codes,
 * load offsets and post-load erase constants
 */
package vec_mem_pkg;

	// 512 KB array, main RAM in bank 0 plus E-disk banks
	localparam int RAM_AW    = 19;
	localparam int RAM_WORDS = 524288;
	localparam int ED_PAGE_W = 3;

	// Byte stream from the file download source
	typedef struct packed {
		logic        active;
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_req_t;

	// File type codes
	localparam logic [7:0] IDX_ROM = 8'h01;
	localparam logic [7:0] IDX_COM = 8'h41;
	localparam logic [7:0] IDX_C00 = 8'h81;
	localparam logic [7:0] IDX_EDD = 8'hC1;

	// Where each file type lands in the array
	localparam logic [24:0] OFS_ROM = 25'h0000100;
	localparam logic [24:0] OFS_COM = 25'h0000100;
	localparam logic [24:0] OFS_C00 = 25'h0000000;
	localparam logic [24:0] OFS_EDD = 25'h0010000;

	// Erase wraps inside bank 0 and stops at the load start
	localparam logic [RAM_AW-1:0] ERASE_MASK = 19'h0FFFF;
	localparam logic [RAM_AW-1:0] ERASE_END  = 19'h00100;
	localparam int                ERASE_DIV  = 2;

endpackage

// File: vec_bus_pkg.sv
/*
 * CPU bus definitions
 * Status word, bus cycle and RAM request structs,
 * joystick control byte views and the I/O port map
 */
package vec_bus_pkg;
	import vec_mem_pkg::*;

	// 8080 status byte, latched at SYNC
	typedef struct packed {
		logic ram_read;
		logic io_read;
		logic m1;
		logic io_write;
		logic halt_ack;
		logic io_stack;
		logic write_n;
		logic int_ack;
	} status_word_t;

	// One CPU bus cycle
	typedef struct packed {
		logic         valid;
		logic         rd;
		logic         wr;
		status_word_t status;
		logic [15:0]  addr;
		logic [7:0]   wdata;
	} cpu_req_t;

	// Request into the shared RAM
	typedef struct packed {
		logic              valid;
		logic              we;
		logic [RAM_AW-1:0] addr;
		logic [7:0]        wdata;
	} ram_req_t;

	// Joystick control byte, whole or as a bit-set command
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic       mode;
			logic [2:0] rsvd;
			logic [2:0] idx;
			logic       val;
		} cmd;
	} joy_ctl_u;

	// ----------------------------------------
	// Port map
	localparam logic [7:0] PORT_PPI_BASE = 8'h00;
	localparam logic [7:0] PORT_JOY_CTL  = 8'h04;
	localparam logic [7:0] PORT_JOY_SEL  = 8'h06;
	localparam logic [7:0] PORT_COVOX    = 8'h07;
	localparam logic [7:0] PORT_JOY_A    = 8'h0E;
	localparam logic [7:0] PORT_JOY_B    = 8'h0F;
	localparam logic [7:0] PORT_EDISK    = 8'h10;

	// Undriven data bus reads high
	localparam logic [7:0] BYTE_IDLE = 8'hFF;

endpackage

// File: vec_cpu_port.sv
/*
 * CPU side of the memory system
 * Status decode, E-disk page mapping, RAM requests,
 * I/O strobes and the registered read-data mux
 */
`timescale 1ns/1ps

module vec_cpu_port
	import vec_bus_pkg::*;
	import vec_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     cold_reset,
	input  cpu_req_t cpu_i,
	input  logic     ram_grant_i,
	input  logic [7:0] ram_rdata_i,
	input  logic [7:0] io_rdata_i,
	input  logic [7:0] ed_reg_i,
	output ram_req_t ram_req_o,
	output logic     io_wr_o,
	output logic     io_rd_o,
	output logic [7:0] io_addr_o,
	output logic [7:0] io_wdata_o,
	output logic     cpu_ready_o,
	output logic [7:0] cpu_rdata_o
);

	status_word_t         st;
	logic                 io_cycle, mem_cycle, accept;
	logic                 ed_win, ed_ram, ed_stack;
	logic [ED_PAGE_W-1:0] ed_page;
	logic                 src_ram;
	logic [7:0]           rdata_q;

	assign st          = cpu_i.status;
	assign io_cycle    = st.io_read | st.io_write;
	assign mem_cycle   = (st.ram_read | ~st.write_n) & ~io_cycle;
	assign cpu_ready_o = ram_grant_i;
	assign accept      = cpu_i.valid & ram_grant_i;

	// ----------------------------------------
	// E-disk window and stack mapping
	assign ed_win = cpu_i.addr[15] & ((cpu_i.addr[14] ^ cpu_i.addr[13]) |
		(ed_reg_i[7] & cpu_i.addr[14] & cpu_i.addr[13]) |
		(ed_reg_i[6] & ~cpu_i.addr[14] & ~cpu_i.addr[13]));
	assign ed_ram   = ed_reg_i[5] & ed_win & mem_cycle;
	assign ed_stack = ed_reg_i[4] & st.io_stack & mem_cycle;

	// Stack mapping wins over the window
	always_comb begin
		if (ed_stack)
			ed_page = {1'b0, ed_reg_i[3:2]} + 3'd1;
		else if (ed_ram)
			ed_page = {1'b0, ed_reg_i[1:0]} + 3'd1;
		else
			ed_page = '0;
	end

	always_comb begin
		ram_req_o.valid = cpu_i.valid & mem_cycle & (cpu_i.rd | cpu_i.wr);
		ram_req_o.we    = cpu_i.wr;
		ram_req_o.addr  = {ed_page, cpu_i.addr};
		ram_req_o.wdata = cpu_i.wdata;
	end

	// Port number sits on the low address byte
	assign io_wr_o    = accept & cpu_i.wr & st.io_write;
	assign io_rd_o    = accept & cpu_i.rd & st.io_read;
	assign io_addr_o  = cpu_i.addr[7:0];
	assign io_wdata_o = cpu_i.wdata;

	// ----------------------------------------
	// Read source picked at acceptance
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			src_ram <= 1'b0;
		end else if (accept && cpu_i.rd) begin
			src_ram <= ~st.int_ack & ~st.io_read;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept && cpu_i.rd) begin
			rdata_q <= st.int_ack ? BYTE_IDLE : io_rdata_i;
		end
	end

	// RAM data arrives one clock after its address
	assign cpu_rdata_o = src_ram ? ram_rdata_i : rdata_q;

	// Stalled CPU keeps its cycle on the bus
	a_req_held: assert property (@(posedge clk_sys) disable iff (cold_reset)
		cpu_i.valid && !cpu_ready_o |=> $stable(cpu_i));

endmodule

// File: vec_io_ports.sv
/*
 * I/O port block
 * Port decode, E-disk paging register, joystick
 * control and remap, covox register
 */
`timescale 1ns/1ps

module vec_io_ports
	import vec_bus_pkg::*;
(
	input  logic       clk_sys,
	input  logic       cold_reset,
	input  logic       io_wr_i,
	input  logic       io_rd_i,
	input  logic [7:0] io_addr_i,
	input  logic [7:0] io_wdata_i,
	input  logic [7:0] joy_a_i,
	input  logic [7:0] joy_b_i,
	output logic [7:0] io_rdata_o,
	output logic [7:0] ed_reg_o,
	output logic [7:0] covox_o
);

	joy_ctl_u   joy_ctl;
	joy_ctl_u   joy_cmd;
	logic [7:0] ed_reg, covox;
	logic [7:0] joy_pu, joy_pu_o, joy_a_o, joy_b_o, joy_p_o;

	// Inverted stick byte with the fire bits on top
	function automatic logic [7:0] stick_port(input logic [7:0] s);
		stick_port = ~{s[5], s[4], 2'b00, s[2], s[3], s[1], s[0]};
	endfunction

	assign joy_cmd = io_wdata_i;

	// ----------------------------------------
	// Write side
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			ed_reg      <= '0;
			joy_ctl.raw <= '0;
			covox       <= '0;
		end else if (io_wr_i) begin
			case (io_addr_i)
				PORT_EDISK:
					ed_reg <= io_wdata_i;
				PORT_COVOX:
					covox <= io_wdata_i;
				PORT_JOY_CTL | 8'h01:
					joy_ctl.raw <= joy_cmd.raw;
				PORT_JOY_CTL: begin
					// Mode bit set leaves the register alone
					if (!joy_cmd.cmd.mode)
						joy_ctl.raw[joy_cmd.cmd.idx] <= joy_cmd.cmd.val;
				end
				default: ;
			endcase
		end
	end

	assign ed_reg_o = ed_reg;
	assign covox_o  = covox;

	// ----------------------------------------
	// Joystick views
	assign joy_pu   = joy_a_i | joy_b_i;
	assign joy_pu_o = {joy_pu[3], joy_pu[0], joy_pu[2], joy_pu[1],
		joy_pu[4], joy_pu[5], 2'b00};
	assign joy_a_o  = stick_port(joy_a_i);
	assign joy_b_o  = stick_port(joy_b_i);

	always_comb begin
		case (joy_ctl.raw[6:5])
			2'b00:   joy_p_o = joy_a_o & joy_b_o;
			2'b01:   joy_p_o = joy_a_o;
			2'b10:   joy_p_o = joy_b_o;
			default: joy_p_o = BYTE_IDLE;
		endcase
	end

	// Bus floats high outside a read strobe
	always_comb begin
		io_rdata_o = BYTE_IDLE;
		if (io_rd_i) begin
			case (io_addr_i)
				PORT_JOY_CTL, PORT_JOY_CTL | 8'h01:
					io_rdata_o = 8'h00;
				PORT_JOY_SEL: io_rdata_o = joy_p_o;
				PORT_COVOX:   io_rdata_o = joy_pu_o;
				PORT_JOY_A:   io_rdata_o = joy_a_o;
				PORT_JOY_B:   io_rdata_o = joy_b_o;
				default:      io_rdata_o = BYTE_IDLE;
			endcase
		end
	end

endmodule

// File: vec_loader.sv
/*
 * File loader
 * Download offsetting per file type and the
 * bank 0 erase that follows a ROM or COM load
 */
`timescale 1ns/1ps

module vec_loader
	import vec_bus_pkg::*;
	import vec_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     cold_reset,
	input  dl_req_t  dl_i,
	output ram_req_t ram_req_o,
	output logic     busy_o
);

	localparam int                DIV_W   = (ERASE_DIV > 1) ? $clog2(ERASE_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_MAX = DIV_W'(ERASE_DIV - 1);

	logic [24:0]       dl_ofs, dl_addr;
	logic [RAM_AW-1:0] last_addr, erase_addr, next_erase;
	logic              old_active, trigger, erasing, erase_wr;
	logic              erase_start, erase_step;
	logic [DIV_W-1:0]  erase_div;

	always_comb begin
		case (dl_i.index)
			IDX_ROM: dl_ofs = OFS_ROM;
			IDX_COM: dl_ofs = OFS_COM;
			IDX_C00: dl_ofs = OFS_C00;
			IDX_EDD: dl_ofs = OFS_EDD;
			default: dl_ofs = '0;
		endcase
	end

	assign dl_addr     = dl_i.addr + dl_ofs;
	assign next_erase  = (erase_addr + 1'b1) & ERASE_MASK;
	assign erase_start = old_active & ~dl_i.active & trigger;
	assign erase_step  = erasing & ~dl_i.active & (erase_div == DIV_MAX);
	assign busy_o      = erase_start | erasing | erase_wr;

	// ----------------------------------------
	// Erase sequencing
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			old_active <= 1'b0;
			trigger    <= 1'b0;
			erasing    <= 1'b0;
			erase_wr   <= 1'b0;
			erase_div  <= '0;
		end else begin
			old_active <= dl_i.active;
			erase_wr   <= 1'b0;
			if (dl_i.active) begin
				// A new download cancels any erase in progress
				trigger <= (dl_i.index == IDX_ROM) || (dl_i.index == IDX_COM);
				erasing <= 1'b0;
			end else if (erase_start) begin
				trigger   <= 1'b0;
				erasing   <= 1'b1;
				erase_div <= '0;
			end else if (erase_step) begin
				erase_div <= '0;
				if (next_erase == ERASE_END)
					erasing <= 1'b0;
				else
					erase_wr <= 1'b1;
			end else if (erasing) begin
				erase_div <= erase_div + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dl_i.active && dl_i.wr)
			last_addr <= dl_addr[RAM_AW-1:0];
		if (erase_start)
			erase_addr <= last_addr;
		else if (erase_step && next_erase != ERASE_END)
			erase_addr <= next_erase;
	end

	// Download bytes first, erase zeros otherwise
	always_comb begin
		if (dl_i.active) begin
			ram_req_o.valid = 1'b1;
			ram_req_o.we    = dl_i.wr;
			ram_req_o.addr  = dl_addr[RAM_AW-1:0];
			ram_req_o.wdata = dl_i.data;
		end else begin
			ram_req_o.valid = erase_wr;
			ram_req_o.we    = erase_wr;
			ram_req_o.addr  = erase_addr;
			ram_req_o.wdata = '0;
		end
	end

	// Erase stays in bank 0 and never reaches the load start
	a_erase_bank0: assert property (@(posedge clk_sys) disable iff (cold_reset)
		erase_wr |-> (erase_addr & ~ERASE_MASK) == '0 && erase_addr != ERASE_END);

endmodule

// File: vec_shared_ram.sv
/*
 * Shared 512 KB RAM
 * Fixed priority arbiter, loader over CPU,
 * in front of a synchronous-read byte array
 */
`timescale 1ns/1ps

module vec_shared_ram
	import vec_bus_pkg::*;
	import vec_mem_pkg::*;
(
	input  logic       clk_sys,
	input  ram_req_t   ldr_req_i,
	input  ram_req_t   cpu_req_i,
	output logic       cpu_grant_o,
	output logic [7:0] rdata_o
);

	ram_req_t   sel;
	logic [7:0] mem [RAM_WORDS];

	// ----------------------------------------
	// Arbitration
	assign cpu_grant_o = ~ldr_req_i.valid;
	assign sel         = ldr_req_i.valid ? ldr_req_i : cpu_req_i;

	// Old data on a read during write
	always_ff @(posedge clk_sys) begin
		if (sel.valid && sel.we)
			mem[sel.addr] <= sel.wdata;
		rdata_o <= mem[sel.addr];
	end

endmodule

// File: vec_top.sv
/*
 * Memory and I/O subsystem top level
 * CPU port, I/O ports, file loader and shared RAM
 */
`timescale 1ns/1ps

module vec_top
	import vec_bus_pkg::*;
	import vec_mem_pkg::*;
(
	input  logic       clk_sys,
	input  logic       cold_reset,
	input  cpu_req_t   cpu_i,
	input  dl_req_t    dl_i,
	input  logic [7:0] joy_a_i,
	input  logic [7:0] joy_b_i,
	output logic       cpu_ready_o,
	output logic [7:0] cpu_rdata_o,
	output logic [7:0] covox_o,
	output logic       loader_busy_o
);

	ram_req_t   cpu_ram_req, ldr_ram_req;
	logic       cpu_grant, io_wr, io_rd;
	logic [7:0] ram_rdata, io_rdata, ed_reg, io_addr, io_wdata;

	vec_cpu_port i_cpu_port (
		.clk_sys     (clk_sys),
		.cold_reset  (cold_reset),
		.cpu_i       (cpu_i),
		.ram_grant_i (cpu_grant),
		.ram_rdata_i (ram_rdata),
		.io_rdata_i  (io_rdata),
		.ed_reg_i    (ed_reg),
		.ram_req_o   (cpu_ram_req),
		.io_wr_o     (io_wr),
		.io_rd_o     (io_rd),
		.io_addr_o   (io_addr),
		.io_wdata_o  (io_wdata),
		.cpu_ready_o (cpu_ready_o),
		.cpu_rdata_o (cpu_rdata_o)
	);

	vec_io_ports i_io_ports (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.io_wr_i    (io_wr),
		.io_rd_i    (io_rd),
		.io_addr_i  (io_addr),
		.io_wdata_i (io_wdata),
		.joy_a_i    (joy_a_i),
		.joy_b_i    (joy_b_i),
		.io_rdata_o (io_rdata),
		.ed_reg_o   (ed_reg),
		.covox_o    (covox_o)
	);

	vec_loader i_loader (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.dl_i       (dl_i),
		.ram_req_o  (ldr_ram_req),
		.busy_o     (loader_busy_o)
	);

	vec_shared_ram i_shared_ram (
		.clk_sys     (clk_sys),
		.ldr_req_i   (ldr_ram_req),
		.cpu_req_i   (cpu_ram_req),
		.cpu_grant_o (cpu_grant),
		.rdata_o     (ram_rdata)
	);

endmodule

// File: tb_vec_top.sv
/*
 * Testbench for the memory and I/O subsystem
 * Table of bus cycles, downloads and port checks applied in a loop,
 * with a small reference model for load offsets and E-disk pages
 */
`timescale 1ns/1ps

module tb_vec_top
	import vec_bus_pkg::*;
	import vec_mem_pkg::*;
();

	localparam int RST_CYCLES = 10;

	// Step kinds
	localparam logic [2:0] K_WR    = 3'd0;
	localparam logic [2:0] K_RD    = 3'd1;
	localparam logic [2:0] K_LDCHK = 3'd2;
	localparam logic [2:0] K_DL    = 3'd3;
	localparam logic [2:0] K_JOY   = 3'd4;
	localparam logic [2:0] K_COVOX = 3'd5;
	localparam logic [2:0] K_RESET = 3'd6;

	// 8080 status bytes
	localparam logic [7:0] ST_MRD  = 8'h82;
	localparam logic [7:0] ST_MWR  = 8'h00;
	localparam logic [7:0] ST_SRD  = 8'h86;
	localparam logic [7:0] ST_SWR  = 8'h04;
	localparam logic [7:0] ST_IRD  = 8'h42;
	localparam logic [7:0] ST_IWR  = 8'h10;
	localparam logic [7:0] ST_INTA = 8'h23;

	// code is the status byte, or the file index for a download
	typedef struct packed {
		logic [2:0]  kind;
		logic [7:0]  code;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  expv;
	} step_t;

	logic       clk_sys = 1'b0;
	logic       cold_reset;
	cpu_req_t   cpu_i;
	dl_req_t    dl_i;
	logic [7:0] joy_a_i, joy_b_i;
	logic       cpu_ready_o, loader_busy_o;
	logic [7:0] cpu_rdata_o, covox_o;

	step_t      steps[$];
	logic [7:0] loaded[int];
	logic [7:0] ref_ed = 8'h00;
	int         seed = 32'ha130f310;
	int         dl_total = 0;
	int         cycles = 0;
	int         limit = 0;

	vec_top i_dut (
		.clk_sys       (clk_sys),
		.cold_reset    (cold_reset),
		.cpu_i         (cpu_i),
		.dl_i          (dl_i),
		.joy_a_i       (joy_a_i),
		.joy_b_i       (joy_b_i),
		.cpu_ready_o   (cpu_ready_o),
		.cpu_rdata_o   (cpu_rdata_o),
		.covox_o       (covox_o),
		.loader_busy_o (loader_busy_o)
	);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: run did not finish within %0d clock cycles", limit);
			$display("** FAIL **");
			$fatal(1, "Simulation timed out");
		end
	end

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERR %s: got 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
			$display("** FAIL **");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// ----------------------------------------
	// Reference rules
	function automatic logic [24:0] load_offset(input logic [7:0] idx);
		case (idx)
			IDX_ROM: load_offset = 25'h0000100;
			IDX_COM: load_offset = 25'h0000100;
			IDX_EDD: load_offset = 25'h0010000;
			default: load_offset = 25'h0000000;
		endcase
	endfunction

	function automatic logic [ED_PAGE_W-1:0] ref_page(input logic [7:0] ed,
		input logic [15:0] a, input logic stack);
		logic win;
		win = a[15] && ((a[14] != a[13]) || (ed[7] && a[14] && a[13]) ||
			(ed[6] && !a[14] && !a[13]));
		if (stack && ed[4])
			ref_page = 3'd1 + {1'b0, ed[3:2]};
		else if (win && ed[5])
			ref_page = 3'd1 + {1'b0, ed[1:0]};
		else
			ref_page = 3'd0;
	endfunction

	// ----------------------------------------
	// Drivers
	task automatic bus_cycle(input logic [7:0] code, input logic [15:0] addr,
		input logic [7:0] wdata, input logic is_rd, output logic [7:0] rdata);
		@(negedge clk_sys);
		cpu_i.valid  = 1'b1;
		cpu_i.rd     = is_rd;
		cpu_i.wr     = !is_rd;
		cpu_i.status = status_word_t'(code);
		cpu_i.addr   = addr;
		cpu_i.wdata  = wdata;
		// Ready only changes at a rising edge here
		while (!cpu_ready_o)
			@(negedge clk_sys);
		@(negedge clk_sys);
		rdata = cpu_rdata_o;
		cpu_i = '0;
	endtask

	task automatic download(input logic [7:0] idx, input logic [15:0] base, input int count);
		logic [7:0]  b;
		logic [24:0] dst;
		for (int n = 0; n < count; n++) begin
			@(negedge clk_sys);
			if (n > 0)
				check("cpu_ready_o", 8'(cpu_ready_o), 8'h00);
			b = 8'($random(seed));
			dl_i.active = 1'b1;
			dl_i.wr     = 1'b1;
			dl_i.index  = idx;
			dl_i.addr   = 25'(base) + 25'(n);
			dl_i.data   = b;
			dst = load_offset(idx) + 25'(base) + 25'(n);
			loaded[int'(dst[RAM_AW-1:0])] = b;
		end
		@(negedge clk_sys);
		check("cpu_ready_o", 8'(cpu_ready_o), 8'h00);
		dl_i = '0;
		@(negedge clk_sys);
		// Only ROM and COM loads start the erase
		check("loader_busy_o", 8'(loader_busy_o),
			8'((idx == IDX_ROM) || (idx == IDX_COM)));
		while (loader_busy_o)
			@(negedge clk_sys);
	endtask

	task automatic apply_reset();
		@(negedge clk_sys);
		cold_reset = 1'b1;
		repeat (RST_CYCLES) @(negedge clk_sys);
		cold_reset = 1'b0;
		ref_ed = 8'h00;
	endtask

	task automatic run_step(input step_t s);
		logic [7:0]        rd;
		logic [15:0]       a;
		logic [RAM_AW-1:0] ram_a;
		status_word_t      st;
		st = status_word_t'(s.code);
		case (s.kind)
			K_WR: begin
				bus_cycle(s.code, s.addr, s.data, 1'b0, rd);
				if (st.io_write && s.addr[7:0] == PORT_EDISK)
					ref_ed = s.data;
			end
			K_RD: begin
				bus_cycle(s.code, s.addr, 8'h00, 1'b1, rd);
				check("cpu_rdata_o", rd, s.expv);
			end
			K_LDCHK: begin
				// Read back downloaded bytes through the page mapping
				for (int i = 0; i < int'(s.data); i++) begin
					a = s.addr + 16'(i);
					ram_a = {ref_page(ref_ed, a, st.io_stack), a};
					bus_cycle(s.code, a, 8'h00, 1'b1, rd);
					check("cpu_rdata_o", rd, loaded[int'(ram_a)]);
				end
			end
			K_DL:
				download(s.code, s.addr, int'(s.data));
			K_JOY: begin
				@(negedge clk_sys);
				joy_a_i = s.addr[15:8];
				joy_b_i = s.addr[7:0];
			end
			K_COVOX: begin
				@(negedge clk_sys);
				check("covox_o", covox_o, s.expv);
			end
			K_RESET:
				apply_reset();
			default: begin
				$display("Table holds a step of unknown kind %0d", s.kind);
				$display("** FAIL **");
				$fatal(1, "Bad table step");
			end
		endcase
	endtask

	task automatic add_step(input logic [2:0] kind, input logic [7:0] code,
		input logic [15:0] addr, input logic [7:0] data, input logic [7:0] expv);
		step_t s;
		s.kind = kind;
		s.code = code;
		s.addr = addr;
		s.data = data;
		s.expv = expv;
		steps.push_back(s);
		if (kind == K_DL)
			dl_total += int'(data);
	endtask

	// ----------------------------------------
	// Stimulus table
	task automatic build_table();
		// Markers that the COM erase must clear
		add_step(K_WR, ST_MWR, 16'h0050, 8'h11, 8'h00);
		add_step(K_WR, ST_MWR, 16'h4000, 8'h22, 8'h00);
		add_step(K_WR, ST_MWR, 16'hFFFF, 8'h33, 8'h00);
		add_step(K_RD, ST_MRD, 16'h4000, 8'h00, 8'h22);
		add_step(K_DL, IDX_COM, 16'h0000, 8'd32, 8'h00);
		add_step(K_LDCHK, ST_MRD, 16'h0100, 8'd32, 8'h00);
		add_step(K_RD, ST_MRD, 16'h0050, 8'h00, 8'h00);
		add_step(K_RD, ST_MRD, 16'h4000, 8'h00, 8'h00);
		add_step(K_RD, ST_MRD, 16'hFFFF, 8'h00, 8'h00);
		// C00 load leaves the rest of bank 0 alone
		add_step(K_WR, ST_MWR, 16'h2000, 8'h5C, 8'h00);
		add_step(K_DL, IDX_C00, 16'h0000, 8'd4, 8'h00);
		add_step(K_RD, ST_MRD, 16'h2000, 8'h00, 8'h5C);
		add_step(K_LDCHK, ST_MRD, 16'h0000, 8'd4, 8'h00);
		add_step(K_LDCHK, ST_MRD, 16'h0100, 8'd32, 8'h00);
		// E-disk window
		add_step(K_WR, ST_MWR, 16'hA000, 8'h6B, 8'h00);
		add_step(K_WR, ST_IWR, 16'h1010, 8'h20, 8'h00);
		add_step(K_WR, ST_MWR, 16'hA000, 8'h9E, 8'h00);
		add_step(K_WR, ST_IWR, 16'h1010, 8'h00, 8'h00);
		add_step(K_RD, ST_MRD, 16'hA000, 8'h00, 8'h6B);
		add_step(K_WR, ST_IWR, 16'h1010, 8'h20, 8'h00);
		add_step(K_RD, ST_MRD, 16'hA000, 8'h00, 8'h9E);
		// E-disk stack mapping against an EDD image
		add_step(K_DL, IDX_EDD, 16'h1234, 8'd1, 8'h00);
		add_step(K_WR, ST_IWR, 16'h1010, 8'h10, 8'h00);
		add_step(K_LDCHK, ST_SRD, 16'h1234, 8'd1, 8'h00);
		add_step(K_WR, ST_SWR, 16'h1234, 8'hC7, 8'h00);
		add_step(K_RD, ST_SRD, 16'h1234, 8'h00, 8'hC7);
		add_step(K_WR, ST_IWR, 16'h1010, 8'h00, 8'h00);
		add_step(K_RD, ST_MRD, 16'h1234, 8'h00, 8'h00);
		// Joysticks, A = 0x05 and B = 0x12
		add_step(K_JOY, 8'h00, 16'h0512, 8'h00, 8'h00);
		add_step(K_RD, ST_IRD, 16'h0707, 8'h00, 8'h78);
		add_step(K_RD, ST_IRD, 16'h0E0E, 8'h00, 8'hF6);
		add_step(K_RD, ST_IRD, 16'h0F0F, 8'h00, 8'hBD);
		add_step(K_WR, ST_IWR, 16'h0505, 8'h20, 8'h00);
		add_step(K_RD, ST_IRD, 16'h0606, 8'h00, 8'hF6);
		add_step(K_WR, ST_IWR, 16'h0505, 8'h40, 8'h00);
		add_step(K_RD, ST_IRD, 16'h0606, 8'h00, 8'hBD);
		add_step(K_WR, ST_IWR, 16'h0505, 8'h00, 8'h00);
		add_step(K_RD, ST_IRD, 16'h0606, 8'h00, 8'hB4);
		add_step(K_WR, ST_IWR, 16'h0404, 8'h0B, 8'h00);
		add_step(K_RD, ST_IRD, 16'h0606, 8'h00, 8'hF6);
		add_step(K_WR, ST_IWR, 16'h0404, 8'h0D, 8'h00);
		add_step(K_RD, ST_IRD, 16'h0606, 8'h00, 8'hFF);
		add_step(K_WR, ST_IWR, 16'h0404, 8'h0A, 8'h00);
		add_step(K_RD, ST_IRD, 16'h0606, 8'h00, 8'hBD);
		add_step(K_WR, ST_IWR, 16'h0404, 8'h0C, 8'h00);
		add_step(K_RD, ST_IRD, 16'h0606, 8'h00, 8'hB4);
		// Mode bit set, command ignored
		add_step(K_WR, ST_IWR, 16'h0404, 8'h8B, 8'h00);
		add_step(K_RD, ST_IRD, 16'h0606, 8'h00, 8'hB4);
		add_step(K_RD, ST_IRD, 16'h0404, 8'h00, 8'h00);
		add_step(K_RD, ST_IRD, 16'h0505, 8'h00, 8'h00);
		// Covox, idle bus reads and reset values
		add_step(K_WR, ST_IWR, 16'h0707, 8'h5A, 8'h00);
		add_step(K_COVOX, 8'h00, 16'h0000, 8'h00, 8'h5A);
		add_step(K_RD, ST_INTA, 16'h0038, 8'h00, 8'hFF);
		add_step(K_RD, ST_IRD, 16'h3030, 8'h00, 8'hFF);
		add_step(K_WR, ST_IWR, 16'h1010, 8'h20, 8'h00);
		add_step(K_RESET, 8'h00, 16'h0000, 8'h00, 8'h00);
		add_step(K_COVOX, 8'h00, 16'h0000, 8'h00, 8'h00);
		add_step(K_RD, ST_MRD, 16'hA000, 8'h00, 8'h6B);
	endtask

	initial begin
		cold_reset = 1'b1;
		cpu_i      = '0;
		dl_i       = '0;
		joy_a_i    = 8'h00;
		joy_b_i    = 8'h00;
		build_table();
		// One full bank 0 erase at most, doubled for margin
		limit = 2 * (RST_CYCLES * 2 + steps.size() * 16 + dl_total * 2 +
			65536 * ERASE_DIV);
		repeat (RST_CYCLES) @(negedge clk_sys);
		cold_reset = 1'b0;
		@(negedge clk_sys);
		check("cpu_ready_o", 8'(cpu_ready_o), 8'h01);
		check("loader_busy_o", 8'(loader_busy_o), 8'h00);
		check("covox_o", covox_o, 8'h00);
		foreach (steps[i])
			run_step(steps[i]);
		$display("** PASS **");
		$finish;
	end

endmodule

// File: vlog.f
vec_mem_pkg.sv
vec_bus_pkg.sv
vec_cpu_port.sv
vec_io_ports.sv
vec_loader.sv
vec_shared_ram.sv
vec_top.sv
tb_vec_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_vec_top \
	-Mdir obj_dir -o tb_vec_top

./obj_dir/tb_vec_top 2>&1 | tee sim.log

if grep -qF '** FAIL **' sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"
